// ==== act_params.svh ====
`ifndef ACT_PARAMS_SVH
`define ACT_PARAMS_SVH

// ------------------------------
// Activation datapath
// ------------------------------
`define ACT_WIDTH      8    // Signed Q4.4 word
`define ACT_FRAC       4    // Fraction bits of the Q4.4 word

// Sparsity reporting
`define ACT_BLOCK_LEN  16   // Elements per block, zero count reported at the end

`endif

// ==== act_pkg.sv ====
`include "act_params.svh"

package act_pkg;

    typedef logic signed [`ACT_WIDTH-1:0] act_word_t;                 // One Q4.4 activation
    typedef logic [$clog2(`ACT_BLOCK_LEN+1)-1:0] zero_count_t;        // Holds 0 to block length

    // Output payload of the unit
    typedef struct packed {
        act_word_t data;                                              // Softshrink result
        logic      last;                                              // Final element of a block
    } act_result_t;

    // ------------------------------
    // Handshake sequencing
    // ------------------------------
    typedef enum logic [1:0] {
        IDLE,                                                         // Waiting for in_req
        IN_ACK,                                                       // in_ack high, wait req low
        OUT_REQ,                                                      // out_req high, wait ack
        OUT_DONE                                                      // Wait for out_ack low
    } hs_state_t;

endpackage

// ==== softshrink_lut.sv ====
`timescale 1ns/1ps

module softshrink_lut #(
    parameter int DATA_IN_0_PRECISION_0  = 8,
    parameter int DATA_IN_0_PRECISION_1  = 4,
    parameter int DATA_OUT_0_PRECISION_0 = 8,
    parameter int DATA_OUT_0_PRECISION_1 = 4
) (
    input  logic [7:0] data_in_0,                   // Q4.4 word
    output logic [7:0] data_out_0                   // Shrunk toward zero by lambda 0.5
);

    always_comb begin
        case (data_in_0)
            8'h00: data_out_0 = 8'h00;              // Dead zone covers -8 to 8
            8'h01: data_out_0 = 8'h00;
            8'h02: data_out_0 = 8'h00;
            8'h03: data_out_0 = 8'h00;
            8'h04: data_out_0 = 8'h00;
            8'h05: data_out_0 = 8'h00;
            8'h06: data_out_0 = 8'h00;
            8'h07: data_out_0 = 8'h00;
            8'h08: data_out_0 = 8'h00;
            8'h09: data_out_0 = 8'h01;              // Positive side loses 8
            8'h0a: data_out_0 = 8'h02;
            8'h0b: data_out_0 = 8'h03;
            8'h0c: data_out_0 = 8'h04;
            8'h0d: data_out_0 = 8'h05;
            8'h0e: data_out_0 = 8'h06;
            8'h0f: data_out_0 = 8'h07;
            8'h10: data_out_0 = 8'h08;
            8'h11: data_out_0 = 8'h09;
            8'h12: data_out_0 = 8'h0a;
            8'h13: data_out_0 = 8'h0b;
            8'h14: data_out_0 = 8'h0c;
            8'h15: data_out_0 = 8'h0d;
            8'h16: data_out_0 = 8'h0e;
            8'h17: data_out_0 = 8'h0f;
            8'h18: data_out_0 = 8'h10;
            8'h19: data_out_0 = 8'h11;
            8'h1a: data_out_0 = 8'h12;
            8'h1b: data_out_0 = 8'h13;
            8'h1c: data_out_0 = 8'h14;
            8'h1d: data_out_0 = 8'h15;
            8'h1e: data_out_0 = 8'h16;
            8'h1f: data_out_0 = 8'h17;
            8'h20: data_out_0 = 8'h18;
            8'h21: data_out_0 = 8'h19;
            8'h22: data_out_0 = 8'h1a;
            8'h23: data_out_0 = 8'h1b;
            8'h24: data_out_0 = 8'h1c;
            8'h25: data_out_0 = 8'h1d;
            8'h26: data_out_0 = 8'h1e;
            8'h27: data_out_0 = 8'h1f;
            8'h28: data_out_0 = 8'h20;
            8'h29: data_out_0 = 8'h21;
            8'h2a: data_out_0 = 8'h22;
            8'h2b: data_out_0 = 8'h23;
            8'h2c: data_out_0 = 8'h24;
            8'h2d: data_out_0 = 8'h25;
            8'h2e: data_out_0 = 8'h26;
            8'h2f: data_out_0 = 8'h27;
            8'h30: data_out_0 = 8'h28;
            8'h31: data_out_0 = 8'h29;
            8'h32: data_out_0 = 8'h2a;
            8'h33: data_out_0 = 8'h2b;
            8'h34: data_out_0 = 8'h2c;
            8'h35: data_out_0 = 8'h2d;
            8'h36: data_out_0 = 8'h2e;
            8'h37: data_out_0 = 8'h2f;
            8'h38: data_out_0 = 8'h30;
            8'h39: data_out_0 = 8'h31;
            8'h3a: data_out_0 = 8'h32;
            8'h3b: data_out_0 = 8'h33;
            8'h3c: data_out_0 = 8'h34;
            8'h3d: data_out_0 = 8'h35;
            8'h3e: data_out_0 = 8'h36;
            8'h3f: data_out_0 = 8'h37;
            8'h40: data_out_0 = 8'h38;
            8'h41: data_out_0 = 8'h39;
            8'h42: data_out_0 = 8'h3a;
            8'h43: data_out_0 = 8'h3b;
            8'h44: data_out_0 = 8'h3c;
            8'h45: data_out_0 = 8'h3d;
            8'h46: data_out_0 = 8'h3e;
            8'h47: data_out_0 = 8'h3f;
            8'h48: data_out_0 = 8'h40;
            8'h49: data_out_0 = 8'h41;
            8'h4a: data_out_0 = 8'h42;
            8'h4b: data_out_0 = 8'h43;
            8'h4c: data_out_0 = 8'h44;
            8'h4d: data_out_0 = 8'h45;
            8'h4e: data_out_0 = 8'h46;
            8'h4f: data_out_0 = 8'h47;
            8'h50: data_out_0 = 8'h48;
            8'h51: data_out_0 = 8'h49;
            8'h52: data_out_0 = 8'h4a;
            8'h53: data_out_0 = 8'h4b;
            8'h54: data_out_0 = 8'h4c;
            8'h55: data_out_0 = 8'h4d;
            8'h56: data_out_0 = 8'h4e;
            8'h57: data_out_0 = 8'h4f;
            8'h58: data_out_0 = 8'h50;
            8'h59: data_out_0 = 8'h51;
            8'h5a: data_out_0 = 8'h52;
            8'h5b: data_out_0 = 8'h53;
            8'h5c: data_out_0 = 8'h54;
            8'h5d: data_out_0 = 8'h55;
            8'h5e: data_out_0 = 8'h56;
            8'h5f: data_out_0 = 8'h57;
            8'h60: data_out_0 = 8'h58;
            8'h61: data_out_0 = 8'h59;
            8'h62: data_out_0 = 8'h5a;
            8'h63: data_out_0 = 8'h5b;
            8'h64: data_out_0 = 8'h5c;
            8'h65: data_out_0 = 8'h5d;
            8'h66: data_out_0 = 8'h5e;
            8'h67: data_out_0 = 8'h5f;
            8'h68: data_out_0 = 8'h60;
            8'h69: data_out_0 = 8'h61;
            8'h6a: data_out_0 = 8'h62;
            8'h6b: data_out_0 = 8'h63;
            8'h6c: data_out_0 = 8'h64;
            8'h6d: data_out_0 = 8'h65;
            8'h6e: data_out_0 = 8'h66;
            8'h6f: data_out_0 = 8'h67;
            8'h70: data_out_0 = 8'h68;
            8'h71: data_out_0 = 8'h69;
            8'h72: data_out_0 = 8'h6a;
            8'h73: data_out_0 = 8'h6b;
            8'h74: data_out_0 = 8'h6c;
            8'h75: data_out_0 = 8'h6d;
            8'h76: data_out_0 = 8'h6e;
            8'h77: data_out_0 = 8'h6f;
            8'h78: data_out_0 = 8'h70;
            8'h79: data_out_0 = 8'h71;
            8'h7a: data_out_0 = 8'h72;
            8'h7b: data_out_0 = 8'h73;
            8'h7c: data_out_0 = 8'h74;
            8'h7d: data_out_0 = 8'h75;
            8'h7e: data_out_0 = 8'h76;
            8'h7f: data_out_0 = 8'h77;
            8'h80: data_out_0 = 8'h88;              // Negative side gains 8
            8'h81: data_out_0 = 8'h89;
            8'h82: data_out_0 = 8'h8a;
            8'h83: data_out_0 = 8'h8b;
            8'h84: data_out_0 = 8'h8c;
            8'h85: data_out_0 = 8'h8d;
            8'h86: data_out_0 = 8'h8e;
            8'h87: data_out_0 = 8'h8f;
            8'h88: data_out_0 = 8'h90;
            8'h89: data_out_0 = 8'h91;
            8'h8a: data_out_0 = 8'h92;
            8'h8b: data_out_0 = 8'h93;
            8'h8c: data_out_0 = 8'h94;
            8'h8d: data_out_0 = 8'h95;
            8'h8e: data_out_0 = 8'h96;
            8'h8f: data_out_0 = 8'h97;
            8'h90: data_out_0 = 8'h98;
            8'h91: data_out_0 = 8'h99;
            8'h92: data_out_0 = 8'h9a;
            8'h93: data_out_0 = 8'h9b;
            8'h94: data_out_0 = 8'h9c;
            8'h95: data_out_0 = 8'h9d;
            8'h96: data_out_0 = 8'h9e;
            8'h97: data_out_0 = 8'h9f;
            8'h98: data_out_0 = 8'ha0;
            8'h99: data_out_0 = 8'ha1;
            8'h9a: data_out_0 = 8'ha2;
            8'h9b: data_out_0 = 8'ha3;
            8'h9c: data_out_0 = 8'ha4;
            8'h9d: data_out_0 = 8'ha5;
            8'h9e: data_out_0 = 8'ha6;
            8'h9f: data_out_0 = 8'ha7;
            8'ha0: data_out_0 = 8'ha8;
            8'ha1: data_out_0 = 8'ha9;
            8'ha2: data_out_0 = 8'haa;
            8'ha3: data_out_0 = 8'hab;
            8'ha4: data_out_0 = 8'hac;
            8'ha5: data_out_0 = 8'had;
            8'ha6: data_out_0 = 8'hae;
            8'ha7: data_out_0 = 8'haf;
            8'ha8: data_out_0 = 8'hb0;
            8'ha9: data_out_0 = 8'hb1;
            8'haa: data_out_0 = 8'hb2;
            8'hab: data_out_0 = 8'hb3;
            8'hac: data_out_0 = 8'hb4;
            8'had: data_out_0 = 8'hb5;
            8'hae: data_out_0 = 8'hb6;
            8'haf: data_out_0 = 8'hb7;
            8'hb0: data_out_0 = 8'hb8;
            8'hb1: data_out_0 = 8'hb9;
            8'hb2: data_out_0 = 8'hba;
            8'hb3: data_out_0 = 8'hbb;
            8'hb4: data_out_0 = 8'hbc;
            8'hb5: data_out_0 = 8'hbd;
            8'hb6: data_out_0 = 8'hbe;
            8'hb7: data_out_0 = 8'hbf;
            8'hb8: data_out_0 = 8'hc0;
            8'hb9: data_out_0 = 8'hc1;
            8'hba: data_out_0 = 8'hc2;
            8'hbb: data_out_0 = 8'hc3;
            8'hbc: data_out_0 = 8'hc4;
            8'hbd: data_out_0 = 8'hc5;
            8'hbe: data_out_0 = 8'hc6;
            8'hbf: data_out_0 = 8'hc7;
            8'hc0: data_out_0 = 8'hc8;
            8'hc1: data_out_0 = 8'hc9;
            8'hc2: data_out_0 = 8'hca;
            8'hc3: data_out_0 = 8'hcb;
            8'hc4: data_out_0 = 8'hcc;
            8'hc5: data_out_0 = 8'hcd;
            8'hc6: data_out_0 = 8'hce;
            8'hc7: data_out_0 = 8'hcf;
            8'hc8: data_out_0 = 8'hd0;
            8'hc9: data_out_0 = 8'hd1;
            8'hca: data_out_0 = 8'hd2;
            8'hcb: data_out_0 = 8'hd3;
            8'hcc: data_out_0 = 8'hd4;
            8'hcd: data_out_0 = 8'hd5;
            8'hce: data_out_0 = 8'hd6;
            8'hcf: data_out_0 = 8'hd7;
            8'hd0: data_out_0 = 8'hd8;
            8'hd1: data_out_0 = 8'hd9;
            8'hd2: data_out_0 = 8'hda;
            8'hd3: data_out_0 = 8'hdb;
            8'hd4: data_out_0 = 8'hdc;
            8'hd5: data_out_0 = 8'hdd;
            8'hd6: data_out_0 = 8'hde;
            8'hd7: data_out_0 = 8'hdf;
            8'hd8: data_out_0 = 8'he0;
            8'hd9: data_out_0 = 8'he1;
            8'hda: data_out_0 = 8'he2;
            8'hdb: data_out_0 = 8'he3;
            8'hdc: data_out_0 = 8'he4;
            8'hdd: data_out_0 = 8'he5;
            8'hde: data_out_0 = 8'he6;
            8'hdf: data_out_0 = 8'he7;
            8'he0: data_out_0 = 8'he8;
            8'he1: data_out_0 = 8'he9;
            8'he2: data_out_0 = 8'hea;
            8'he3: data_out_0 = 8'heb;
            8'he4: data_out_0 = 8'hec;
            8'he5: data_out_0 = 8'hed;
            8'he6: data_out_0 = 8'hee;
            8'he7: data_out_0 = 8'hef;
            8'he8: data_out_0 = 8'hf0;
            8'he9: data_out_0 = 8'hf1;
            8'hea: data_out_0 = 8'hf2;
            8'heb: data_out_0 = 8'hf3;
            8'hec: data_out_0 = 8'hf4;
            8'hed: data_out_0 = 8'hf5;
            8'hee: data_out_0 = 8'hf6;
            8'hef: data_out_0 = 8'hf7;
            8'hf0: data_out_0 = 8'hf8;
            8'hf1: data_out_0 = 8'hf9;
            8'hf2: data_out_0 = 8'hfa;
            8'hf3: data_out_0 = 8'hfb;
            8'hf4: data_out_0 = 8'hfc;
            8'hf5: data_out_0 = 8'hfd;
            8'hf6: data_out_0 = 8'hfe;
            8'hf7: data_out_0 = 8'hff;
            8'hf8: data_out_0 = 8'h00;              // -8 is inside the dead zone
            8'hf9: data_out_0 = 8'h00;
            8'hfa: data_out_0 = 8'h00;
            8'hfb: data_out_0 = 8'h00;
            8'hfc: data_out_0 = 8'h00;
            8'hfd: data_out_0 = 8'h00;
            8'hfe: data_out_0 = 8'h00;
            8'hff: data_out_0 = 8'h00;
            default: data_out_0 = 8'h00;
        endcase
    end

endmodule

// ==== shrink_stage.sv ====
`timescale 1ns/1ps
`include "act_params.svh"

module shrink_stage import act_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        capture,
    input  act_word_t   in_data,
    input  logic        last,
    output logic        is_zero,
    output act_result_t out_data
);

    logic [7:0] lut_out;

    softshrink_lut #(
        .DATA_IN_0_PRECISION_0  (`ACT_WIDTH),
        .DATA_IN_0_PRECISION_1  (`ACT_FRAC),
        .DATA_OUT_0_PRECISION_0 (`ACT_WIDTH),
        .DATA_OUT_0_PRECISION_1 (`ACT_FRAC)
    ) softshrink_lut_i (
        .data_in_0  (in_data),
        .data_out_0 (lut_out)
    );

    assign is_zero = (lut_out == 8'h00);                    // Feeds the block sparsity tally

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_data <= '0;
        end else if (capture) begin
            out_data.data <= act_word_t'(lut_out);          // Held through the output handshake
            out_data.last <= last;
        end
    end

endmodule

// ==== handshake_fsm.sv ====
`timescale 1ns/1ps

module handshake_fsm import act_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_req,
    output logic in_ack,
    output logic out_req,
    input  logic out_ack,
    output logic capture
);

    hs_state_t state;

    // One strobe per item, in the cycle the request is first seen
    assign capture = (state == IDLE) && in_req;

    // ------------------------------
    // Four-phase sequencing
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (in_req) begin
                        state  <= IN_ACK;
                        in_ack <= 1'b1;         // Data is latched on this edge
                    end
                end
                IN_ACK: begin
                    if (!in_req) begin
                        state   <= OUT_REQ;
                        in_ack  <= 1'b0;
                        out_req <= 1'b1;        // out_ack is already low here
                    end
                end
                OUT_REQ: begin
                    if (out_ack) begin
                        state   <= OUT_DONE;
                        out_req <= 1'b0;
                    end
                end
                OUT_DONE: begin
                    if (!out_ack) begin
                        state <= IDLE;          // Consumer returned to zero
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== elem_counter.sv ====
`timescale 1ns/1ps
`include "act_params.svh"

module elem_counter import act_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        capture,
    input  logic        is_zero,
    output logic        last,
    output zero_count_t block_zeros
);

    localparam int IDX_W = $clog2(`ACT_BLOCK_LEN);

    logic [IDX_W-1:0] elem_idx;
    zero_count_t      zero_tally;
    zero_count_t      tally_next;

    assign last       = (elem_idx == IDX_W'(`ACT_BLOCK_LEN - 1));
    assign tally_next = zero_tally + zero_count_t'(is_zero);       // Includes the current element

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            elem_idx    <= '0;
            zero_tally  <= '0;
            block_zeros <= '0;
        end else if (capture) begin
            if (last) begin
                elem_idx    <= '0;
                zero_tally  <= '0;
                block_zeros <= tally_next;      // Ready before out_req of the last element
            end else begin
                elem_idx    <= elem_idx + IDX_W'(1);
                zero_tally  <= tally_next;
            end
        end
    end

endmodule

// ==== act_unit.sv ====
`timescale 1ns/1ps

module act_unit import act_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_req,
    input  act_word_t   in_data,
    output logic        in_ack,
    output logic        out_req,
    output act_result_t out_data,
    input  logic        out_ack,
    output zero_count_t block_zeros
);

    logic capture;
    logic is_zero;
    logic last;

    handshake_fsm handshake_fsm_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .in_req  (in_req),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_ack (out_ack),
        .capture (capture)
    );

    elem_counter elem_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .capture     (capture),
        .is_zero     (is_zero),
        .last        (last),
        .block_zeros (block_zeros)
    );

    shrink_stage shrink_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .capture  (capture),
        .in_data  (in_data),
        .last     (last),
        .is_zero  (is_zero),
        .out_data (out_data)
    );

endmodule

// ==== act_checker.sv ====
`timescale 1ns/1ps
`include "act_params.svh"

module act_checker import act_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_req,
    input  act_word_t   in_data,
    input  logic        in_ack,
    input  logic        out_req,
    input  act_result_t out_data,
    input  logic        out_ack,
    input  zero_count_t block_zeros,
    input  logic        run_done,
    output logic        report_done,
    output int          error_count
);

    localparam int LAMBDA_RAW = 1 << (`ACT_FRAC - 1);      // 0.5 in Q4.4

    act_word_t accepted_q[$];
    act_word_t exp_data;
    logic      exp_last;
    logic      prev_in_ack = 1'b0;
    logic      prev_out_req = 1'b0;
    logic      prev_out_ack = 1'b0;
    logic      busy = 1'b0;                                 // An item is inside the unit
    logic      expect_ack = 1'b0;
    int        out_count = 0;
    int        block_tally = 0;
    int        data_errs = 0;
    int        last_errs = 0;
    int        zero_errs = 0;
    int        proto_errs = 0;

    initial report_done = 1'b0;

    assign error_count = data_errs + last_errs + zero_errs + proto_errs;

    function automatic act_word_t softshrink_ref(act_word_t x);
        int v;
        v = int'(x);
        if (v > LAMBDA_RAW) begin
            return act_word_t'(v - LAMBDA_RAW);
        end else if (v < -LAMBDA_RAW) begin
            return act_word_t'(v + LAMBDA_RAW);
        end
        return '0;
    endfunction

    // ------------------------------
    // Sampling on the rising edge
    // ------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            if (in_ack !== 1'b0 || out_req !== 1'b0 || block_zeros !== '0) begin
                proto_errs++;
                $display("ERROR at %0t: outputs not low during reset", $time);
            end
            busy       = 1'b0;
            expect_ack = 1'b0;
        end else begin
            if (expect_ack && !in_ack) begin
                proto_errs++;
                $display("ERROR at %0t: in_ack did not rise one cycle after in_req", $time);
            end
            expect_ack = 1'b0;
            if (!busy && in_req) begin
                busy       = 1'b1;                          // Unit captures on this edge
                expect_ack = 1'b1;
            end
            if (in_ack && !prev_in_ack) begin
                if (out_req || prev_out_ack) begin
                    proto_errs++;
                    $display("ERROR at %0t: in_ack rose before the output side was idle", $time);
                end
                accepted_q.push_back(in_data);
            end
            if (out_req && !prev_out_req) begin
                if (prev_out_ack) begin                     // out_ack on the edge out_req rose
                    proto_errs++;
                    $display("ERROR at %0t: out_req rose while out_ack was high", $time);
                end
                if (accepted_q.size() == 0) begin
                    proto_errs++;
                    $display("ERROR at %0t: output produced with no accepted input", $time);
                end else begin
                    exp_data = softshrink_ref(accepted_q.pop_front());
                    exp_last = ((out_count % `ACT_BLOCK_LEN) == `ACT_BLOCK_LEN - 1);
                    if (out_data.data !== exp_data) begin
                        data_errs++;
                        $display("FAILED at %0t: out_data.data expected %0d got %0d",
                                 $time, exp_data, out_data.data);
                    end
                    if (out_data.last !== exp_last) begin
                        last_errs++;
                        $display("FAILED at %0t: out_data.last expected %0b got %0b",
                                 $time, exp_last, out_data.last);
                    end
                    if (exp_data == '0) begin
                        block_tally++;
                    end
                    if (exp_last) begin
                        if (block_zeros !== zero_count_t'(block_tally)) begin
                            zero_errs++;
                            $display("FAILED at %0t: block_zeros expected %0d got %0d",
                                     $time, block_tally, block_zeros);
                        end
                        block_tally = 0;
                    end
                    out_count++;
                end
            end
            if (prev_out_ack && !out_ack) begin
                busy = 1'b0;                                // Unit is back in IDLE
            end
        end
        prev_in_ack  = in_ack;
        prev_out_req = out_req;
        prev_out_ack = out_ack;

        if (run_done && !report_done) begin
            if (accepted_q.size() != 0) begin
                proto_errs++;
                $display("ERROR: %0d accepted inputs were never produced", accepted_q.size());
            end
            $display("Checked %0d outputs, errors data=%0d last=%0d zeros=%0d protocol=%0d",
                     out_count, data_errs, last_errs, zero_errs, proto_errs);
            report_done = 1'b1;
        end
    end

endmodule

// ==== tb_act_unit.sv ====
`timescale 1ns/1ps
`include "act_params.svh"

module tb_act_unit import act_pkg::*; ();

    localparam int NUM_ITEMS   = `ACT_BLOCK_LEN * 16;
    localparam int CYCLE_LIMIT = NUM_ITEMS * 40 + 100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_req;
    act_word_t   in_data;
    logic        in_ack;
    logic        out_req;
    act_result_t out_data;
    logic        out_ack;
    zero_count_t block_zeros;
    logic        run_done;
    logic        report_done;
    int          error_count;
    int          outputs_done;
    int          cycle_count = 0;

    always #20 clk = ~clk;

    act_unit act_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_data     (in_data),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_data    (out_data),
        .out_ack     (out_ack),
        .block_zeros (block_zeros)
    );

    act_checker act_checker_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_data     (in_data),
        .in_ack      (in_ack),
        .out_req     (out_req),
        .out_data    (out_data),
        .out_ack     (out_ack),
        .block_zeros (block_zeros),
        .run_done    (run_done),
        .report_done (report_done),
        .error_count (error_count)
    );

    // Edges of the dead zone come first, then random words
    function automatic act_word_t next_stimulus(int idx);
        case (idx)
            0:       return act_word_t'(0);
            1:       return act_word_t'(8);
            2:       return act_word_t'(9);
            3:       return act_word_t'(-8);
            4:       return act_word_t'(-9);
            5:       return act_word_t'(127);
            6:       return act_word_t'(-128);
            default: return act_word_t'($urandom);
        endcase
    endfunction

    // ------------------------------
    // Producer side
    // ------------------------------
    initial begin : drive_inputs
        int gap;
        void'($urandom(32'h412f));
        rst_n    = 1'b0;
        in_req   = 1'b0;
        in_data  = '0;
        run_done = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        $display("Sending %0d Q%0d.%0d values", NUM_ITEMS, `ACT_WIDTH - `ACT_FRAC, `ACT_FRAC);
        for (int i = 0; i < NUM_ITEMS; i++) begin
            gap = $urandom_range(0, 5);
            repeat (gap) @(negedge clk);
            in_data = next_stimulus(i);
            in_req  = 1'b1;
            do @(negedge clk); while (!in_ack);
            in_req = 1'b0;
            do @(negedge clk); while (in_ack);              // Return to zero before the next item
        end
        while (outputs_done < NUM_ITEMS) @(negedge clk);
        repeat (4) @(negedge clk);
        run_done = 1'b1;
        while (!report_done) @(negedge clk);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // ------------------------------
    // Consumer side
    // ------------------------------
    initial begin : answer_outputs
        int delay;
        out_ack      = 1'b0;
        outputs_done = 0;
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                delay = $urandom_range(0, 7);
                repeat (delay) @(negedge clk);
                out_ack = 1'b1;
                do @(negedge clk); while (out_req);
                delay = $urandom_range(0, 3);
                repeat (delay) @(negedge clk);
                out_ack = 1'b0;
                outputs_done++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: timeout after %0d cycles with %0d of %0d items done",
                     cycle_count, outputs_done, NUM_ITEMS);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

// ==== act_unit.f ====
+incdir+.
act_pkg.sv
softshrink_lut.sv
shrink_stage.sv
handshake_fsm.sv
elem_counter.sv
act_unit.sv
act_checker.sv
tb_act_unit.sv

// ==== Makefile ====
TOP := tb_act_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f act_unit.f --top-module $(TOP)

sim:
	verilator --binary --timing --timescale 1ns/1ps -f act_unit.f --top-module $(TOP) -o sim_act_unit
	@out="$$(./obj_dir/sim_act_unit)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
